/* outmux_config.svh */
// Build-time sizes for the ALU output multiplexer
// Data bus width, lanes per data bit and bus-source code width

`ifndef OUTMUX_CONFIG_SVH
`define OUTMUX_CONFIG_SVH

// Width of D, G and every operand bus
`define OUTMUX_WIDTH 16

// Source lanes feeding one D bit
`define OUTMUX_LANES 8

// Bits in the bus-source code
`define OUTMUX_CODE_W 5

`endif

/* outmux_pkg.sv */
// Shared types for the ALU output multiplexer
// Bus-source and G select encodings, control word, decoded lane enables,
// operand bundle and the per-bit lane vector

`default_nettype none

`include "outmux_config.svh"

package outmux_pkg;

  typedef enum logic [`OUTMUX_CODE_W-1:0] {
    IDBS_NONE     = 'd0,   // D held at zero
    IDBS_EA       = 'd1,
    IDBS_DBR      = 'd2,
    IDBS_ARG      = 'd3,
    IDBS_STS      = 'd4,
    IDBS_SW       = 'd5,
    IDBS_FIDB     = 'd6,
    IDBS_GPR      = 'd7,   // Full GPR word
    IDBS_GPR_LO   = 'd8,   // GPR low byte, high byte zero
    IDBS_GPR_SEXT = 'd9,   // GPR low byte, sign extended
    IDBS_LARG     = 'd10   // Packed loop-argument field
  } idbs_code_e;

  typedef enum logic [1:0] {
    G_FROM_D = 2'd0,
    G_FROM_A = 2'd1,
    G_FROM_F = 2'd2
  } g_sel_e;

  typedef struct packed {
    idbs_code_e code;   // What drives D
    g_sel_e     g_sel;  // What drives G
  } outmux_ctrl_t;

  typedef struct packed {
    logic ebmg;    // EA
    logic edbr;
    logic earg;
    logic ests;
    logic eswap;   // SW
    logic efidb;
    logic egprl;   // GPR bits 7:0
    logic egprh;   // GPR bits 15:8
    logic egprs;   // GPR bit 7 into the high byte
    logic ebarg;   // LBA into bits 2:0
    logic eabarg;  // AARG0 into bit 3
    logic eaarg;   // LAA into bits 6:4
  } lane_en_t;

  typedef struct packed {
    logic [`OUTMUX_WIDTH-1:0] ea;
    logic [`OUTMUX_WIDTH-1:0] dbr;
    logic [`OUTMUX_WIDTH-1:0] arg;
    logic [`OUTMUX_WIDTH-1:0] sts;
    logic [`OUTMUX_WIDTH-1:0] sw;
    logic [`OUTMUX_WIDTH-1:0] fidbi;
    logic [`OUTMUX_WIDTH-1:0] gpr;
    logic [`OUTMUX_WIDTH-1:0] a;      // G source only
    logic [`OUTMUX_WIDTH-1:0] f;      // G source only
    logic [2:0]               lba;
    logic [2:0]               laa;
    logic                     aarg0;
  } operand_bus_t;

  typedef logic [`OUTMUX_LANES-1:0] lane_vec_t;

endpackage

`default_nettype wire

/* outmux_idbs_decode.sv */
// Bus-source control register and its decoder
// Loads the control word on sysclk under ctrl_load and turns the
// registered code into lane enables, passing the G select through

`timescale 1ns/1ns
`default_nettype none

module outmux_idbs_decode (
  input  wire                           sysclk,
  input  wire                           reset,
  input  wire                           ctrl_load,
  input  wire outmux_pkg::outmux_ctrl_t ctrl,
  output outmux_pkg::lane_en_t          lane_en,
  output outmux_pkg::g_sel_e            g_sel
);

  outmux_pkg::outmux_ctrl_t ctrl_q;  // Registered source and G select

  always_ff @(posedge sysclk) begin
    if (reset) begin
      ctrl_q.code  <= outmux_pkg::IDBS_NONE;  // D reads zero after reset
      ctrl_q.g_sel <= outmux_pkg::G_FROM_D;
    end else if (ctrl_load) begin
      ctrl_q <= ctrl;
    end
  end

  // One lane group per code, everything else stays off
  always_comb begin
    lane_en = '0;
    case (ctrl_q.code)
      outmux_pkg::IDBS_EA: begin
        lane_en.ebmg = 1'b1;
      end
      outmux_pkg::IDBS_DBR: begin
        lane_en.edbr = 1'b1;
      end
      outmux_pkg::IDBS_ARG: begin
        lane_en.earg = 1'b1;
      end
      outmux_pkg::IDBS_STS: begin
        lane_en.ests = 1'b1;
      end
      outmux_pkg::IDBS_SW: begin
        lane_en.eswap = 1'b1;
      end
      outmux_pkg::IDBS_FIDB: begin
        lane_en.efidb = 1'b1;
      end
      outmux_pkg::IDBS_GPR: begin
        lane_en.egprl = 1'b1;  // Both bytes
        lane_en.egprh = 1'b1;
      end
      outmux_pkg::IDBS_GPR_LO: begin
        lane_en.egprl = 1'b1;
      end
      outmux_pkg::IDBS_GPR_SEXT: begin
        lane_en.egprl = 1'b1;
        lane_en.egprs = 1'b1;  // Bit 7 fans out to 15:8
      end
      outmux_pkg::IDBS_LARG: begin
        lane_en.ebarg  = 1'b1;
        lane_en.eabarg = 1'b1;
        lane_en.eaarg  = 1'b1;
      end
      default: begin
        lane_en = '0;  // NONE and unused codes
      end
    endcase
  end

  assign g_sel = ctrl_q.g_sel;

  // Whatever the sequencer loads must be a code the table knows
  a_code_legal: assert property (@(posedge sysclk) disable iff (reset)
    ctrl_load |=> ctrl_q.code inside {[outmux_pkg::IDBS_NONE : outmux_pkg::IDBS_LARG]});

  // Encoding 3 has no G source behind it
  a_gsel_legal: assert property (@(posedge sysclk) disable iff (reset)
    ctrl_load |=> ctrl_q.g_sel inside {outmux_pkg::G_FROM_D, outmux_pkg::G_FROM_A,
                                       outmux_pkg::G_FROM_F});

endmodule

`default_nettype wire

/* outmux_lane_map.sv */
// Per-bit lane routing for the D bus
// Lanes 0..5 carry the whole-word buses, lane 6 the GPR byte lanes,
// lane 7 the loop-argument field in the low byte and the GPR sign bit
// in the high byte

`timescale 1ns/1ns
`default_nettype none

`include "outmux_config.svh"

module outmux_lane_map (
  input  wire outmux_pkg::lane_en_t                  lane_en,
  input  wire outmux_pkg::operand_bus_t              ops,
  output outmux_pkg::lane_vec_t [`OUTMUX_WIDTH-1:0] bit_en,
  output outmux_pkg::lane_vec_t [`OUTMUX_WIDTH-1:0] bit_src
);

  localparam int BYTE_W   = `OUTMUX_WIDTH / 2;  // Low byte is bits 7:0
  localparam int SIGN_BIT = BYTE_W - 1;         // GPR bit copied by SEXT
  localparam int LBA_W    = $bits(ops.lba);
  localparam int AARG_BIT = LBA_W;              // AARG0 sits above LBA
  localparam int LAA_LO   = AARG_BIT + 1;
  localparam int LAA_TOP  = LAA_LO + $bits(ops.laa);

  for (genvar i = 0; i < `OUTMUX_WIDTH; i++) begin : g_bit
    logic gpr_en;   // Lane 6 enable
    logic aux_en;   // Lane 7 enable
    logic aux_src;  // Lane 7 data

    if (i < BYTE_W) begin : g_lo
      assign gpr_en = lane_en.egprl;

      if (i < LBA_W) begin : g_lba
        assign aux_en  = lane_en.ebarg;
        assign aux_src = ops.lba[i];
      end else if (i == AARG_BIT) begin : g_aarg
        assign aux_en  = lane_en.eabarg;
        assign aux_src = ops.aarg0;
      end else if (i < LAA_TOP) begin : g_laa
        assign aux_en  = lane_en.eaarg;
        assign aux_src = ops.laa[i-LAA_LO];
      end else begin : g_none
        // Bit 7 has no lane 7 source
        assign aux_en  = 1'b0;
        assign aux_src = 1'b0;
      end
    end else begin : g_hi
      assign gpr_en  = lane_en.egprh;
      assign aux_en  = lane_en.egprs;
      assign aux_src = ops.gpr[SIGN_BIT];  // Sign extension of GPR byte
    end

    assign bit_en[i] = {
      aux_en,
      gpr_en,
      lane_en.efidb,
      lane_en.eswap,
      lane_en.ests,
      lane_en.earg,
      lane_en.edbr,
      lane_en.ebmg
    };

    assign bit_src[i] = {
      aux_src,
      ops.gpr[i],
      ops.fidbi[i],
      ops.sw[i],
      ops.sts[i],
      ops.arg[i],
      ops.dbr[i],
      ops.ea[i]
    };
  end

endmodule

`default_nettype wire

/* outmux_bit_slice.sv */
// One bit of the output multiplexer
// AND-OR selector over the eight source lanes for D, and the
// three-way D/A/F selector for G

`timescale 1ns/1ns
`default_nettype none

module outmux_bit_slice (
  input  wire                        sysclk,
  input  wire outmux_pkg::lane_vec_t bit_en,
  input  wire outmux_pkg::lane_vec_t bit_src,
  input  wire outmux_pkg::g_sel_e    g_sel,
  input  wire                        a_bit,
  input  wire                        f_bit,
  output logic                       d_bit,
  output logic                       g_bit
);

  assign d_bit = |(bit_en & bit_src);  // Zero when no lane is enabled

  always_comb begin
    case (g_sel)
      outmux_pkg::G_FROM_D: g_bit = d_bit;
      outmux_pkg::G_FROM_A: g_bit = a_bit;
      outmux_pkg::G_FROM_F: g_bit = f_bit;
      default:              g_bit = 1'b0;
    endcase
  end

  // Decoder and lane map together must never open two lanes on one bit
  a_lane_onehot: assert property (@(posedge sysclk)
    !$isunknown(bit_en) |-> $onehot0(bit_en));

endmodule

`default_nettype wire

/* outmux_top.sv */
// ALU output multiplexer top level
// Control register and decoder, per-bit lane map and the sixteen
// D/G bit slices

`timescale 1ns/1ns
`default_nettype none

`include "outmux_config.svh"

module outmux_top (
  input  wire                           sysclk,
  input  wire                           reset,
  input  wire                           ctrl_load,
  input  wire outmux_pkg::outmux_ctrl_t ctrl,
  input  wire outmux_pkg::operand_bus_t ops,
  output wire [`OUTMUX_WIDTH-1:0]       d,
  output wire [`OUTMUX_WIDTH-1:0]       g
);

  outmux_pkg::lane_en_t                      lane_en;  // Decoded lane groups
  outmux_pkg::g_sel_e                        g_sel;
  outmux_pkg::lane_vec_t [`OUTMUX_WIDTH-1:0] bit_en;
  outmux_pkg::lane_vec_t [`OUTMUX_WIDTH-1:0] bit_src;

  outmux_idbs_decode u_decode (
    .sysclk    (sysclk),
    .reset     (reset),
    .ctrl_load (ctrl_load),
    .ctrl      (ctrl),
    .lane_en   (lane_en),
    .g_sel     (g_sel)
  );

  outmux_lane_map u_lane_map (
    .lane_en (lane_en),
    .ops     (ops),
    .bit_en  (bit_en),
    .bit_src (bit_src)
  );

  for (genvar i = 0; i < `OUTMUX_WIDTH; i++) begin : g_slice
    outmux_bit_slice u_slice (
      .sysclk  (sysclk),
      .bit_en  (bit_en[i]),
      .bit_src (bit_src[i]),
      .g_sel   (g_sel),
      .a_bit   (ops.a[i]),
      .f_bit   (ops.f[i]),
      .d_bit   (d[i]),
      .g_bit   (g[i])
    );
  end

endmodule

`default_nettype wire

/* outmux_checker.sv */
// Scoreboard for the ALU output multiplexer
// Shadow copy of the control register, reference model of D and G,
// falling-edge comparison and error counting

`timescale 1ns/1ns
`default_nettype none

`include "outmux_config.svh"

module outmux_checker (
  input  wire                           sysclk,
  input  wire                           reset,
  input  wire                           ctrl_load,
  input  wire outmux_pkg::outmux_ctrl_t ctrl,
  input  wire outmux_pkg::operand_bus_t ops,
  input  wire [`OUTMUX_WIDTH-1:0]       d,
  input  wire [`OUTMUX_WIDTH-1:0]       g,
  input  wire [3:0]                     test_id,
  output logic [31:0]                   error_count,
  output logic [31:0]                   check_count
);

  outmux_pkg::outmux_ctrl_t model_ctrl;  // Shadow of the DUT control register

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_idle";
      4'd2:    return "whole_word";
      4'd3:    return "gpr_byte";
      4'd4:    return "loop_arg";
      4'd5:    return "g_select";
      4'd6:    return "hold_select";
      default: return "startup";
    endcase
  endfunction

  // Expected G in the upper half, expected D in the lower half
  function automatic logic [2*`OUTMUX_WIDTH-1:0] reference_out(
    input outmux_pkg::outmux_ctrl_t sel,
    input outmux_pkg::operand_bus_t src
  );
    logic [`OUTMUX_WIDTH-1:0] dv;
    logic [`OUTMUX_WIDTH-1:0] gv;
    case (sel.code)
      outmux_pkg::IDBS_EA:       dv = src.ea;
      outmux_pkg::IDBS_DBR:      dv = src.dbr;
      outmux_pkg::IDBS_ARG:      dv = src.arg;
      outmux_pkg::IDBS_STS:      dv = src.sts;
      outmux_pkg::IDBS_SW:       dv = src.sw;
      outmux_pkg::IDBS_FIDB:     dv = src.fidbi;
      outmux_pkg::IDBS_GPR:      dv = src.gpr;
      outmux_pkg::IDBS_GPR_LO:   dv = {8'h00, src.gpr[7:0]};
      outmux_pkg::IDBS_GPR_SEXT: dv = {{8{src.gpr[7]}}, src.gpr[7:0]};  // Sign bit copied up
      outmux_pkg::IDBS_LARG:     dv = {9'd0, src.laa, src.aarg0, src.lba};
      default:                   dv = '0;  // NONE drives nothing
    endcase
    case (sel.g_sel)
      outmux_pkg::G_FROM_D: gv = dv;
      outmux_pkg::G_FROM_A: gv = src.a;
      outmux_pkg::G_FROM_F: gv = src.f;
      default:              gv = '0;
    endcase
    return {gv, dv};
  endfunction

  always_ff @(posedge sysclk) begin
    if (reset) begin
      model_ctrl.code  <= outmux_pkg::IDBS_NONE;
      model_ctrl.g_sel <= outmux_pkg::G_FROM_D;
    end else if (ctrl_load) begin
      model_ctrl <= ctrl;  // Same edge as the DUT register
    end
  end

  // Outputs are settled half a cycle after the stimulus edge
  always @(negedge sysclk) begin
    logic [2*`OUTMUX_WIDTH-1:0] exp_out;
    logic [`OUTMUX_WIDTH-1:0]   exp_d;
    logic [`OUTMUX_WIDTH-1:0]   exp_g;
    if (reset) begin
      error_count = 0;
      check_count = 0;
    end else begin
      exp_out = reference_out(model_ctrl, ops);
      exp_d   = exp_out[`OUTMUX_WIDTH-1:0];
      exp_g   = exp_out[2*`OUTMUX_WIDTH-1:`OUTMUX_WIDTH];
      check_count = check_count + 2;
      if (d !== exp_d) begin
        error_count = error_count + 1;
        $display("CHECK FAILED %s at %0t: d expected %h, actual %h",
                 test_name(test_id), $time, exp_d, d);
      end
      if (g !== exp_g) begin
        error_count = error_count + 1;
        $display("CHECK FAILED %s at %0t: g expected %h, actual %h",
                 test_name(test_id), $time, exp_g, g);
      end
    end
  end

endmodule

`default_nettype wire

/* tb_outmux.sv */
// Testbench for the ALU output multiplexer
// Clock and reset, seeded random operands, control loads for every
// bus source and G select, watchdog and the closing summary

`timescale 1ns/1ns
`default_nettype none

`include "outmux_config.svh"

module tb_outmux;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 3;
  localparam int IDLE_CYCLES  = 8;
  localparam int HOLD_CYCLES  = 8;   // Cycles kept after each load
  localparam int NUM_LOADS    = 15;
  localparam int DRIFT_CYCLES = 10;
  localparam int TAIL_CYCLES  = 2;
  localparam int TEST_CYCLES  = RESET_CYCLES + IDLE_CYCLES + NUM_LOADS * (1 + HOLD_CYCLES)
                                + DRIFT_CYCLES + TAIL_CYCLES;
  localparam int TIMEOUT_NS   = TEST_CYCLES * CLK_PERIOD + 500;

  logic                     sysclk;
  logic                     reset;
  logic                     ctrl_load;
  outmux_pkg::outmux_ctrl_t ctrl;
  outmux_pkg::operand_bus_t ops;
  wire [`OUTMUX_WIDTH-1:0]  d;
  wire [`OUTMUX_WIDTH-1:0]  g;
  logic [3:0]               test_id;  // Label for error lines
  logic [31:0]              error_count;
  logic [31:0]              check_count;

  outmux_top uut (
    .sysclk    (sysclk),
    .reset     (reset),
    .ctrl_load (ctrl_load),
    .ctrl      (ctrl),
    .ops       (ops),
    .d         (d),
    .g         (g)
  );

  outmux_checker u_checker (
    .sysclk      (sysclk),
    .reset       (reset),
    .ctrl_load   (ctrl_load),
    .ctrl        (ctrl),
    .ops         (ops),
    .d           (d),
    .g           (g),
    .test_id     (test_id),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD/2) sysclk = ~sysclk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [`OUTMUX_WIDTH-1:0] rand_word();
    logic [31:0] r;
    r = $urandom;
    return r[`OUTMUX_WIDTH-1:0];
  endfunction

  function automatic outmux_pkg::operand_bus_t rand_ops();
    outmux_pkg::operand_bus_t o;
    logic [31:0]              r;
    o.ea    = rand_word();
    o.dbr   = rand_word();
    o.arg   = rand_word();
    o.sts   = rand_word();
    o.sw    = rand_word();
    o.fidbi = rand_word();
    o.gpr   = rand_word();
    o.a     = rand_word();
    o.f     = rand_word();
    r       = $urandom;
    o.lba   = r[2:0];
    o.laa   = r[5:3];
    o.aarg0 = r[6];
    return o;
  endfunction

  // Fresh operands every cycle, control untouched
  task automatic run_idle(input int cycles);
    repeat (cycles) begin
      @(posedge sysclk);
      ops <= rand_ops();
    end
  endtask

  task automatic load_and_hold(input outmux_pkg::idbs_code_e code,
                               input outmux_pkg::g_sel_e     sel);
    @(posedge sysclk);
    ctrl_load  <= 1'b1;
    ctrl.code  <= code;
    ctrl.g_sel <= sel;
    ops        <= rand_ops();
    repeat (HOLD_CYCLES) begin
      @(posedge sysclk);
      ctrl_load <= 1'b0;
      ops       <= rand_ops();
    end
  endtask

  // ctrl wanders while the load strobe stays low
  task automatic drift_ctrl(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      @(posedge sysclk);
      r = $urandom;
      ctrl_load  <= 1'b0;
      ctrl.code  <= outmux_pkg::idbs_code_e'({1'b0, r[3:0]} % 5'd11);
      ctrl.g_sel <= outmux_pkg::g_sel_e'(r[5:4] % 2'd3);
      ops        <= rand_ops();
    end
  endtask

  initial begin : main_seq
    int c;
    void'($urandom(32'hc1d4d26f));
    reset      = 1'b1;
    ctrl_load  = 1'b0;
    ctrl.code  = outmux_pkg::IDBS_NONE;
    ctrl.g_sel = outmux_pkg::G_FROM_D;
    ops        = '0;
    test_id    = 4'd0;
    repeat (RESET_CYCLES) @(posedge sysclk);
    reset   <= 1'b0;
    test_id <= 4'd1;
    run_idle(IDLE_CYCLES);

    test_id <= 4'd2;
    for (c = 1; c <= 7; c++) begin
      load_and_hold(outmux_pkg::idbs_code_e'(c[4:0]), outmux_pkg::G_FROM_D);
    end

    test_id <= 4'd3;
    load_and_hold(outmux_pkg::IDBS_GPR_LO, outmux_pkg::G_FROM_D);
    load_and_hold(outmux_pkg::IDBS_GPR_SEXT, outmux_pkg::G_FROM_D);

    test_id <= 4'd4;
    load_and_hold(outmux_pkg::IDBS_LARG, outmux_pkg::G_FROM_D);

    test_id <= 4'd5;
    load_and_hold(outmux_pkg::IDBS_EA, outmux_pkg::G_FROM_A);
    load_and_hold(outmux_pkg::IDBS_GPR_SEXT, outmux_pkg::G_FROM_F);
    load_and_hold(outmux_pkg::IDBS_LARG, outmux_pkg::G_FROM_A);
    load_and_hold(outmux_pkg::IDBS_NONE, outmux_pkg::G_FROM_F);

    test_id <= 4'd6;
    load_and_hold(outmux_pkg::IDBS_DBR, outmux_pkg::G_FROM_D);
    drift_ctrl(DRIFT_CYCLES);
    run_idle(TAIL_CYCLES);

    @(negedge sysclk);
    #1;  // Let the last comparison land
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
outmux_pkg.sv
outmux_idbs_decode.sv
outmux_lane_map.sv
outmux_bit_slice.sv
outmux_top.sv
outmux_checker.sv
tb_outmux.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_outmux
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
